/* hdl/lc3b_pkg.sv */
package lc3b_pkg;

    // One data or address word
    typedef logic [15:0] lc3b_word;

    // Standard LC-3b opcode encodings
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11
    } lc3b_aluop;

    // Three views of one instruction word
    typedef union packed {
        struct packed {
            lc3b_opcode opcode;
            logic [2:0] dest;
            logic [2:0] src1;
            logic       imm;
            // Bits 4:0 hold imm5, or 00 and src2 in register form
            union packed {
                logic [4:0] imm5;
                struct packed {
                    logic [1:0] pad;
                    logic [2:0] src2;
                } regs;
            } tail;
        } operate;
        struct packed {
            lc3b_opcode opcode;
            logic [2:0] dest;
            logic [2:0] base;
            logic [5:0] offset6;
        } offset;
        struct packed {
            lc3b_opcode opcode;
            logic [2:0] nzp;
            logic [8:0] offset9;
        } branch;
    } lc3b_instr;

endpackage

/* hdl/regfile.sv */
module regfile import lc3b_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic [2:0] dest,
    input  logic [2:0] src_a,
    input  logic [2:0] src_b,
    input  lc3b_word   in,
    output lc3b_word   reg_a,
    output lc3b_word   reg_b
);

    lc3b_word data [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            data <= '{default: '0};
        end else if (load) begin
            data[dest] <= in;
        end
    end

    // Asynchronous read ports
    assign reg_a = data[src_a];
    assign reg_b = data[src_b];

endmodule

/* hdl/cpu_datapath.sv */
module cpu_datapath import lc3b_pkg::*; #(
    parameter lc3b_word RESET_PC = 16'h0000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       load_pc,
    input  logic       load_ir,
    input  logic       load_regfile,
    input  logic       load_mar,
    input  logic       load_mdr,
    input  logic       load_cc,
    input  logic [1:0] pcmux_sel,
    input  logic [1:0] alumux_sel,
    input  logic       regfilemux_sel,
    input  logic       marmux_sel,
    input  logic       mdrmux_sel,
    input  lc3b_aluop  aluop,
    input  lc3b_word   mem_rdata,
    input  logic       mem_resp,
    output lc3b_opcode opcode,
    output logic       inst5,
    output logic       branch_enable,
    output lc3b_word   mem_address,
    output lc3b_word   mem_wdata
);

    lc3b_word   pc;
    lc3b_instr  ir;
    lc3b_word   mar;
    lc3b_word   mdr;
    logic [2:0] cc;
    logic [2:0] cc_next;
    logic [2:0] src_b;
    lc3b_word   reg_a;
    lc3b_word   reg_b;
    lc3b_word   imm5_sext;
    lc3b_word   off6_sext;
    lc3b_word   off9_sext;
    lc3b_word   alumux_out;
    lc3b_word   alu_out;
    lc3b_word   pcmux_out;
    lc3b_word   regfilemux_out;
    lc3b_word   marmux_out;
    lc3b_word   mdrmux_out;

    // STR reads its source register through port B
    assign src_b = (ir.operate.opcode == op_str) ? ir.offset.dest : ir.operate.tail.regs.src2;

    // Port A serves src1, the base register and the JMP target alike
    regfile u_regfile (
        .clk   (clk),
        .rst   (rst),
        .load  (load_regfile),
        .dest  (ir.operate.dest),
        .src_a (ir.operate.src1),
        .src_b (src_b),
        .in    (regfilemux_out),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    assign imm5_sext = {{11{ir.operate.tail.imm5[4]}}, ir.operate.tail.imm5};
    assign off6_sext = {{9{ir.offset.offset6[5]}}, ir.offset.offset6, 1'b0};
    assign off9_sext = {{6{ir.branch.offset9[8]}}, ir.branch.offset9, 1'b0};

    always_comb begin
        case (alumux_sel)
            2'b00:   alumux_out = reg_b;
            2'b01:   alumux_out = imm5_sext;
            default: alumux_out = off6_sext;
        endcase
    end

    // Pass forwards operand B, which is how STR reaches the MDR
    always_comb begin
        case (aluop)
            alu_add: alu_out = reg_a + alumux_out;
            alu_and: alu_out = reg_a & alumux_out;
            alu_not: alu_out = ~reg_a;
            default: alu_out = alumux_out;
        endcase
    end

    always_comb begin
        case (pcmux_sel)
            2'b00:   pcmux_out = pc + 16'd2;
            2'b01:   pcmux_out = pc + off9_sext;
            default: pcmux_out = reg_a;
        endcase
    end

    assign regfilemux_out = regfilemux_sel ? mdr : alu_out;
    assign marmux_out     = marmux_sel ? pc : alu_out;
    assign mdrmux_out     = mdrmux_sel ? mem_rdata : alu_out;

    // nzp of the value going into the register file
    always_comb begin
        if (regfilemux_out[15]) begin
            cc_next = 3'b100;
        end else if (regfilemux_out == '0) begin
            cc_next = 3'b010;
        end else begin
            cc_next = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc  <= RESET_PC;
            mar <= RESET_PC;
            cc  <= 3'b010;
        end else begin
            if (load_pc) pc <= pcmux_out;
            if (load_mar) mar <= marmux_out;
            if (load_cc) cc <= cc_next;
        end
    end

    // Read data is taken only in the response cycle
    always_ff @(posedge clk) begin
        if (load_ir) ir <= mdr;
        if (load_mdr && (mem_resp || !mdrmux_sel)) mdr <= mdrmux_out;
    end

    assign opcode        = ir.operate.opcode;
    assign inst5         = ir.operate.imm;
    assign branch_enable = |(ir.branch.nzp & cc);
    assign mem_address   = mar;
    assign mem_wdata     = mdr;

endmodule

/* hdl/cpu_control.sv */
module cpu_control import lc3b_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  lc3b_opcode opcode,
    input  logic       inst5,
    input  logic       branch_enable,
    input  logic       mem_resp,
    output logic       load_pc,
    output logic       load_ir,
    output logic       load_regfile,
    output logic       load_mar,
    output logic       load_mdr,
    output logic       load_cc,
    output logic [1:0] pcmux_sel,
    output logic [1:0] alumux_sel,
    output logic       regfilemux_sel,
    output logic       marmux_sel,
    output logic       mdrmux_sel,
    output lc3b_aluop  aluop,
    output logic       mem_read,
    output logic       mem_write
);

    typedef enum logic [3:0] {
        s_fetch1, s_fetch2, s_fetch3, s_decode,
        s_add, s_and, s_not,
        s_br, s_br_taken, s_jmp,
        s_calc_addr_w, s_ldr1, s_ldr2, s_str1, s_str2
    } state_t;

    state_t state;
    state_t next_state;

    always_comb begin
        load_pc        = 1'b0;
        load_ir        = 1'b0;
        load_regfile   = 1'b0;
        load_mar       = 1'b0;
        load_mdr       = 1'b0;
        load_cc        = 1'b0;
        pcmux_sel      = 2'b00;
        alumux_sel     = 2'b00;
        regfilemux_sel = 1'b0;
        marmux_sel     = 1'b0;
        mdrmux_sel     = 1'b0;
        aluop          = alu_add;
        mem_read       = 1'b0;
        mem_write      = 1'b0;

        case (state)
            s_fetch1: begin
                // MAR from PC, PC advances by 2
                marmux_sel = 1'b1;
                load_mar   = 1'b1;
                load_pc    = 1'b1;
            end
            s_fetch2, s_ldr1: begin
                mem_read   = 1'b1;
                mdrmux_sel = 1'b1;
                load_mdr   = 1'b1;
            end
            s_fetch3: load_ir = 1'b1;
            s_add, s_and, s_not: begin
                alumux_sel   = inst5 ? 2'b01 : 2'b00;
                aluop        = (state == s_add) ? alu_add :
                               (state == s_and) ? alu_and : alu_not;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            s_br_taken: begin
                pcmux_sel = 2'b01;
                load_pc   = 1'b1;
            end
            s_jmp: begin
                pcmux_sel = 2'b10;
                load_pc   = 1'b1;
            end
            s_calc_addr_w: begin
                // Base plus offset6 shifted left
                alumux_sel = 2'b10;
                load_mar   = 1'b1;
            end
            s_ldr2: begin
                regfilemux_sel = 1'b1;
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end
            s_str1: begin
                aluop    = alu_pass;
                load_mdr = 1'b1;
            end
            s_str2: mem_write = 1'b1;
            default: begin
            end
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            s_fetch1: next_state = s_fetch2;
            s_fetch2: if (mem_resp) next_state = s_fetch3;
            s_fetch3: next_state = s_decode;
            s_decode: begin
                case (opcode)
                    op_add:         next_state = s_add;
                    op_and:         next_state = s_and;
                    op_not:         next_state = s_not;
                    op_br:          next_state = s_br;
                    op_jmp:         next_state = s_jmp;
                    op_ldr, op_str: next_state = s_calc_addr_w;
                    // Unsupported opcodes simply fetch again
                    default:        next_state = s_fetch1;
                endcase
            end
            s_br: next_state = branch_enable ? s_br_taken : s_fetch1;
            s_calc_addr_w: next_state = (opcode == op_str) ? s_str1 : s_ldr1;
            s_ldr1: if (mem_resp) next_state = s_ldr2;
            s_str1: next_state = s_str2;
            s_str2: if (mem_resp) next_state = s_fetch1;
            default: next_state = s_fetch1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_fetch1;
        end else begin
            state <= next_state;
        end
    end

endmodule

/* hdl/cpu.sv */
module cpu import lc3b_pkg::*; #(
    parameter lc3b_word RESET_PC = 16'h0000
) (
    input  logic     clk,
    input  logic     rst,
    input  lc3b_word mem_rdata,
    input  logic     mem_resp,
    output lc3b_word mem_address,
    output lc3b_word mem_wdata,
    output logic     mem_read,
    output logic     mem_write
);

    lc3b_opcode opcode;
    logic       inst5;
    logic       branch_enable;
    logic       load_pc;
    logic       load_ir;
    logic       load_regfile;
    logic       load_mar;
    logic       load_mdr;
    logic       load_cc;
    logic [1:0] pcmux_sel;
    logic [1:0] alumux_sel;
    logic       regfilemux_sel;
    logic       marmux_sel;
    logic       mdrmux_sel;
    lc3b_aluop  aluop;

    cpu_control u_control (
        .clk            (clk),
        .rst            (rst),
        .opcode         (opcode),
        .inst5          (inst5),
        .branch_enable  (branch_enable),
        .mem_resp       (mem_resp),
        .load_pc        (load_pc),
        .load_ir        (load_ir),
        .load_regfile   (load_regfile),
        .load_mar       (load_mar),
        .load_mdr       (load_mdr),
        .load_cc        (load_cc),
        .pcmux_sel      (pcmux_sel),
        .alumux_sel     (alumux_sel),
        .regfilemux_sel (regfilemux_sel),
        .marmux_sel     (marmux_sel),
        .mdrmux_sel     (mdrmux_sel),
        .aluop          (aluop),
        .mem_read       (mem_read),
        .mem_write      (mem_write)
    );

    cpu_datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk            (clk),
        .rst            (rst),
        .load_pc        (load_pc),
        .load_ir        (load_ir),
        .load_regfile   (load_regfile),
        .load_mar       (load_mar),
        .load_mdr       (load_mdr),
        .load_cc        (load_cc),
        .pcmux_sel      (pcmux_sel),
        .alumux_sel     (alumux_sel),
        .regfilemux_sel (regfilemux_sel),
        .marmux_sel     (marmux_sel),
        .mdrmux_sel     (mdrmux_sel),
        .aluop          (aluop),
        .mem_rdata      (mem_rdata),
        .mem_resp       (mem_resp),
        .opcode         (opcode),
        .inst5          (inst5),
        .branch_enable  (branch_enable),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata)
    );

endmodule

/* tests/cpu_assertions.sv */
module cpu_assertions import lc3b_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     mem_read,
    input logic     mem_write,
    input logic     mem_resp,
    input lc3b_word mem_address
);

    int failures = 0;

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write))
    else begin
        failures++;
        $error("mem_read and mem_write are high in the same cycle");
    end

    // Strobe and address hold until the response
    a_read_held: assert property (@(posedge clk) disable iff (rst)
        mem_read && !mem_resp |=> mem_read && $stable(mem_address))
    else begin
        failures++;
        $error("mem_read or mem_address changed before mem_resp");
    end

    a_write_held: assert property (@(posedge clk) disable iff (rst)
        mem_write && !mem_resp |=> mem_write && $stable(mem_address))
    else begin
        failures++;
        $error("mem_write or mem_address changed before mem_resp");
    end

    // Strobe drops right after its response
    a_strobe_drops: assert property (@(posedge clk) disable iff (rst)
        (mem_read || mem_write) && mem_resp |=> !mem_read && !mem_write)
    else begin
        failures++;
        $error("strobe still high in the cycle after mem_resp");
    end

    a_even_address: assert property (@(posedge clk) disable iff (rst)
        (mem_read || mem_write) |-> !mem_address[0])
    else begin
        failures++;
        $error("odd mem_address on an access");
    end

    a_idle_after_reset: assert property (@(posedge clk)
        rst |=> !mem_read && !mem_write)
    else begin
        failures++;
        $error("strobe high in the cycle after rst");
    end

endmodule

bind cpu cpu_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .mem_resp    (mem_resp),
    .mem_address (mem_address)
);

/* tests/cpu_tb.sv */
module cpu_tb import lc3b_pkg::*; ();

    localparam lc3b_word RESET_PC   = 16'h0020;
    localparam lc3b_word CODE_END   = 16'h0100;
    localparam lc3b_word BASE       = 16'h0120;
    localparam lc3b_word JMP_TARGET = 16'h00c0;
    localparam int       TIMEOUT    = 500;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    lc3b_word mem_rdata = '0;
    logic     mem_resp = 1'b0;
    lc3b_word mem_address;
    lc3b_word mem_wdata;
    logic     mem_read;
    logic     mem_write;

    lc3b_word mem [256];
    lc3b_word read_log [$];
    lc3b_word store_addr [$];
    lc3b_word store_data [$];
    integer   seed = 32'h0c2d_e10a;
    bit       busy = 1'b0;
    int       wait_left = 0;
    int       max_wait = 0;
    int       errors = 0;
    int       passed = 0;
    int       failed = 0;
    lc3b_word code_ptr;
    lc3b_word first_branch;
    lc3b_word jmp_addr;

    cpu #(
        .RESET_PC (RESET_PC)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_read    (mem_read),
        .mem_write   (mem_write)
    );

    always #20 clk = ~clk;

    // Word memory that answers each strobe after 0 to 3 wait cycles
    always @(negedge clk) begin
        if (rst || mem_resp) begin
            mem_resp = 1'b0;
            busy     = 1'b0;
        end else if (mem_read || mem_write) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
                if (wait_left > max_wait) begin
                    max_wait = wait_left;
                end
            end
            if (wait_left == 0) begin
                mem_resp = 1'b1;
                if (mem_read) begin
                    mem_rdata = mem[mem_address[8:1]];
                    read_log.push_back(mem_address);
                end else begin
                    mem[mem_address[8:1]] = mem_wdata;
                    store_addr.push_back(mem_address);
                    store_data.push_back(mem_wdata);
                end
            end else begin
                wait_left--;
            end
        end
    end

    function automatic lc3b_word reg_operate(lc3b_opcode op, int d, int s1, int s2);
        lc3b_instr i;
        i = '0;
        i.operate.opcode         = op;
        i.operate.dest           = d[2:0];
        i.operate.src1           = s1[2:0];
        i.operate.tail.regs.src2 = s2[2:0];
        return i;
    endfunction

    function automatic lc3b_word imm_operate(lc3b_opcode op, int d, int s1, int imm);
        lc3b_instr i;
        i = '0;
        i.operate.opcode    = op;
        i.operate.dest      = d[2:0];
        i.operate.src1      = s1[2:0];
        i.operate.imm       = 1'b1;
        i.operate.tail.imm5 = imm[4:0];
        return i;
    endfunction

    // LDR, STR and JMP share the offset layout
    function automatic lc3b_word offset_instr(lc3b_opcode op, int r, int base, int off);
        lc3b_instr i;
        i.offset.opcode  = op;
        i.offset.dest    = r[2:0];
        i.offset.base    = base[2:0];
        i.offset.offset6 = off[5:0];
        return i;
    endfunction

    function automatic lc3b_word branch_instr(logic [2:0] nzp, int off);
        lc3b_instr i;
        i.branch.opcode  = op_br;
        i.branch.nzp     = nzp;
        i.branch.offset9 = off[8:0];
        return i;
    endfunction

    task automatic place(input lc3b_word word);
        mem[code_ptr[8:1]] = word;
        code_ptr = code_ptr + 16'd2;
    endtask

    function automatic bit find_store(input lc3b_word addr, output lc3b_word data);
        data = '0;
        foreach (store_addr[k]) begin
            if (store_addr[k] == addr) begin
                data = store_data[k];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic int read_index(input lc3b_word addr);
        foreach (read_log[k]) begin
            if (read_log[k] == addr) begin
                return k;
            end
        end
        return -1;
    endfunction

    // First store to addr or the first read of it
    task automatic wait_access(input bit is_store, input lc3b_word addr, output lc3b_word data);
        int cycles;
        bit found;
        cycles = 0;
        found  = 1'b0;
        data   = '0;
        while (!found && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (is_store) begin
                found = find_store(addr, data);
            end else begin
                found = (read_index(addr) >= 0);
            end
        end
        if (!found) begin
            $display("Timeout: the %s at address 0x%04h never arrived",
                     is_store ? "store" : "fetch", addr);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input lc3b_word exp, input lc3b_word got);
        assert (got === exp)
        else begin
            $display("CHECK FAILED %s expected 0x%04h got 0x%04h", name, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            passed++;
            $display("Test %s: pass", name);
        end else begin
            failed++;
            $display("Test %s: fail with %0d errors", name, errors - err_start);
        end
    endtask

    initial begin
        lc3b_word a_val;
        lc3b_word b_val;
        lc3b_word ld_val;
        lc3b_word got;
        lc3b_word prev;
        int       idx;
        int       err_start;
        bit       at_branch;

        a_val  = 16'h1234;
        b_val  = 16'h0f0f;
        ld_val = 16'h5a3c;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {~i[7:0], i[7:0]};
        end
        mem[0] = BASE;
        mem[1] = a_val;
        mem[2] = b_val;
        mem[3] = JMP_TARGET;
        // Byte address 0x0118 is four words below BASE
        mem[8'h8c] = ld_val;

        code_ptr = RESET_PC;
        place(offset_instr(op_ldr, 7, 0, 0));
        place(offset_instr(op_ldr, 1, 0, 1));
        place(offset_instr(op_ldr, 2, 0, 2));
        place(reg_operate(op_add, 3, 1, 2));
        place(offset_instr(op_str, 3, 7, 0));
        place(imm_operate(op_add, 4, 1, -5));
        place(offset_instr(op_str, 4, 7, 1));
        place(imm_operate(op_and, 5, 2, -3));
        place(offset_instr(op_str, 5, 7, 2));
        place(imm_operate(op_not, 6, 1, -1));
        place(offset_instr(op_str, 6, 7, 3));
        place(offset_instr(op_ldr, 1, 7, -4));
        place(offset_instr(op_str, 1, 7, -1));
        // Markers R5 = 1 and R6 = 2
        place(imm_operate(op_add, 5, 0, 1));
        place(imm_operate(op_add, 6, 0, 2));
        place(imm_operate(op_and, 3, 3, 0));
        first_branch = code_ptr;
        place(branch_instr(3'b010, 1));
        place(offset_instr(op_str, 5, 7, 4));
        place(offset_instr(op_str, 6, 7, 4));
        place(imm_operate(op_add, 3, 0, 7));
        place(branch_instr(3'b100, 1));
        place(offset_instr(op_str, 6, 7, 5));
        place(offset_instr(op_str, 5, 7, 5));
        place(offset_instr(op_ldr, 4, 0, 3));
        jmp_addr = code_ptr;
        place(offset_instr(op_jmp, 0, 4, 0));
        place(offset_instr(op_str, 5, 7, 6));
        code_ptr = JMP_TARGET;
        place(offset_instr(op_str, 6, 7, 6));
        // Spin in place once done
        place(branch_instr(3'b111, -1));

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        err_start = errors;
        wait_access(1'b0, first_branch, got);
        check_word("mem_address", RESET_PC, read_log[0]);
        prev      = read_log[0];
        at_branch = 1'b0;
        for (idx = 1; idx < read_log.size() && !at_branch; idx++) begin
            // Data reads sit outside the code region
            if (read_log[idx] >= RESET_PC && read_log[idx] < CODE_END) begin
                check_word("mem_address", prev + 16'd2, read_log[idx]);
                prev      = read_log[idx];
                at_branch = (prev == first_branch);
            end
        end
        report_test("reset and fetch", err_start);

        err_start = errors;
        wait_access(1'b1, BASE, got);
        check_word("mem_wdata", a_val + b_val, got);
        wait_access(1'b1, BASE + 16'd2, got);
        check_word("mem_wdata", a_val - 16'd5, got);
        wait_access(1'b1, BASE + 16'd4, got);
        check_word("mem_wdata", b_val & 16'hfffd, got);
        wait_access(1'b1, BASE + 16'd6, got);
        check_word("mem_wdata", ~a_val, got);
        report_test("arithmetic", err_start);

        err_start = errors;
        wait_access(1'b1, BASE - 16'd2, got);
        check_word("mem_wdata", ld_val, got);
        report_test("negative offsets", err_start);

        err_start = errors;
        // BRz after a zero result is taken and skips the store of marker 1
        wait_access(1'b1, BASE + 16'd8, got);
        check_word("mem_wdata", 16'd2, got);
        // BRn after a positive result falls through to the store of marker 2
        wait_access(1'b1, BASE + 16'd10, got);
        check_word("mem_wdata", 16'd2, got);
        report_test("branches", err_start);

        err_start = errors;
        wait_access(1'b1, BASE + 16'd12, got);
        check_word("mem_wdata", 16'd2, got);
        idx = read_index(jmp_addr);
        if (idx >= 0 && idx + 1 < read_log.size()) begin
            check_word("mem_address", JMP_TARGET, read_log[idx + 1]);
        end else begin
            $display("The fetch of the JMP or of its target was never seen");
            errors++;
        end
        report_test("jmp", err_start);

        err_start = errors;
        assert (max_wait > 0)
        else begin
            $display("The memory model never inserted a wait cycle");
            errors++;
        end
        assert (u_dut.u_assertions.failures == 0)
        else begin
            $display("A memory protocol assertion failed");
            errors++;
        end
        report_test("back-pressure", err_start);

        $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0 && errors == 0 && u_dut.u_assertions.failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
hdl/lc3b_pkg.sv
hdl/regfile.sv
hdl/cpu_datapath.sv
hdl/cpu_control.sv
hdl/cpu.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv

/* Bender.yml */
package:
  name: lc3b_cpu

sources:
  - files:
      - hdl/lc3b_pkg.sv
      - hdl/regfile.sv
      - hdl/cpu_datapath.sv
      - hdl/cpu_control.sv
      - hdl/cpu.sv
  - target: test
    files:
      - tests/cpu_assertions.sv
      - tests/cpu_tb.sv
